// File: scope_pkg.sv
/* Sizes, register map and state encodings of the oscilloscope capture design.
   DEPTH and N_CHANNELS must be powers of two and N_CHANNELS at least 2.
   The DMA builds word addresses by concatenating channel and sample index. */
package scope_pkg;

    localparam int N_CHANNELS   = 2;
    localparam int CH_WIDTH     = $clog2(N_CHANNELS);
    localparam int SAMPLE_WIDTH = 16;
    localparam int DEPTH        = 16;
    localparam int INDEX_WIDTH  = $clog2(DEPTH);
    localparam int ADDR_WIDTH   = 16;

    // AXI4-Lite geometry of the register file
    localparam int AXI_ADDR_WIDTH = 8;
    localparam int AXI_DATA_WIDTH = 32;

    localparam logic [AXI_ADDR_WIDTH-1:0] REG_CTRL   = 8'h00;
    localparam logic [AXI_ADDR_WIDTH-1:0] REG_LEVEL  = 8'h04;
    localparam logic [AXI_ADDR_WIDTH-1:0] REG_PRE    = 8'h08;
    localparam logic [AXI_ADDR_WIDTH-1:0] REG_BASE   = 8'h0C;
    localparam logic [AXI_ADDR_WIDTH-1:0] REG_STATUS = 8'h10;

    // Bit positions inside CTRL and STATUS
    localparam int CTRL_ARM_BIT       = 0;
    localparam int CTRL_SEL_BIT       = 1;
    localparam int STATUS_ARMED_BIT   = 0;
    localparam int STATUS_TRIG_BIT    = 1;
    localparam int STATUS_DONE_BIT    = 2;

    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    typedef enum logic [1:0] {
        TRIG_IDLE,
        TRIG_ARMED,
        TRIG_TRIGGERED
    } trig_state_t;

    typedef enum logic [1:0] {
        BUF_FILLING,
        BUF_POST,
        BUF_FULL
    } buf_state_t;

    typedef enum logic [1:0] {
        DMA_IDLE,
        DMA_REQUEST,
        DMA_WRITE,
        DMA_DONE
    } dma_state_t;

endpackage

// File: scope_if.sv
/* Read side of one channel's capture buffer.
   rd_data is valid on the cycle after rd_en and holds until the next rd_en. */
`timescale 1ns/1ps

interface capture_rd_if import scope_pkg::*; ();

    logic                    full;
    logic                    rd_en;
    logic [INDEX_WIDTH-1:0]  rd_index;
    logic [SAMPLE_WIDTH-1:0] rd_data;

    modport buffer (
        output full,
        output rd_data,
        input  rd_en,
        input  rd_index
    );

    modport engine (
        input  full,
        input  rd_data,
        output rd_en,
        output rd_index
    );

endinterface

// File: trigger_engine.sv
/* AXI4-Lite register file and level-crossing trigger.
   Arming is accepted only from IDLE, so a CTRL write during a capture only
   changes the channel select. Samples are compared as unsigned values. */
`timescale 1ns/1ps

module trigger_engine import scope_pkg::*; (
    input  logic                                   clock,
    input  logic                                   rst,
    input  logic                                   in_valid,
    input  logic [N_CHANNELS-1:0][SAMPLE_WIDTH-1:0] in_data,
    input  logic                                   dma_done,
    input  logic [AXI_ADDR_WIDTH-1:0]              s_awaddr,
    input  logic                                   s_awvalid,
    output logic                                   s_awready,
    input  logic [AXI_DATA_WIDTH-1:0]              s_wdata,
    input  logic                                   s_wvalid,
    output logic                                   s_wready,
    output logic [1:0]                             s_bresp,
    output logic                                   s_bvalid,
    input  logic                                   s_bready,
    input  logic [AXI_ADDR_WIDTH-1:0]              s_araddr,
    input  logic                                   s_arvalid,
    output logic                                   s_arready,
    output logic [AXI_DATA_WIDTH-1:0]              s_rdata,
    output logic [1:0]                             s_rresp,
    output logic                                   s_rvalid,
    input  logic                                   s_rready,
    output logic                                   trigger,
    output logic [INDEX_WIDTH-1:0]                 pre_count,
    output logic [ADDR_WIDTH-1:0]                  base_addr,
    output logic                                   capture_clear
);

    trig_state_t             state;
    logic [CH_WIDTH-1:0]     trig_sel;
    logic [SAMPLE_WIDTH-1:0] level;
    logic [SAMPLE_WIDTH-1:0] watched;
    logic [SAMPLE_WIDTH-1:0] prev_sample;
    logic                    prev_valid;
    logic [INDEX_WIDTH-1:0]  stored;
    logic                    complete;
    logic                    wr_fire;
    logic                    rd_fire;
    logic                    arm_req;
    logic                    crossing;

    // Address and data are taken together, one write in flight at a time
    assign wr_fire   = s_awvalid && s_wvalid && !s_bvalid;
    assign s_awready = wr_fire;
    assign s_wready  = wr_fire;
    assign s_bresp   = AXI_RESP_OKAY;
    assign rd_fire   = s_arvalid && !s_rvalid;
    assign s_arready = rd_fire;
    assign s_rresp   = AXI_RESP_OKAY;

    assign arm_req  = wr_fire && (s_awaddr == REG_CTRL) && s_wdata[CTRL_ARM_BIT]
                      && (state == TRIG_IDLE);
    assign watched  = in_data[trig_sel];

    // Rising crossing, counted only once PRE samples precede it since arming
    assign crossing = (state == TRIG_ARMED) && in_valid && prev_valid
                      && (prev_sample < level) && (watched >= level)
                      && (stored >= pre_count);

    // The buffers are released in the same cycle as the DMA reports done
    assign capture_clear = dma_done;

    always_ff @(posedge clock) begin
        if (rst) begin
            trig_sel  <= '0;
            level     <= '0;
            pre_count <= '0;
            base_addr <= '0;
        end else if (wr_fire) begin
            case (s_awaddr)
                REG_CTRL:  trig_sel  <= s_wdata[CTRL_SEL_BIT +: CH_WIDTH];
                REG_LEVEL: level     <= s_wdata[SAMPLE_WIDTH-1:0];
                REG_PRE:   pre_count <= s_wdata[INDEX_WIDTH-1:0];
                REG_BASE:  base_addr <= s_wdata[ADDR_WIDTH-1:0];
                default: ;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            s_bvalid <= 1'b0;
            s_rvalid <= 1'b0;
        end else begin
            if (wr_fire) begin
                s_bvalid <= 1'b1;
            end else if (s_bready) begin
                s_bvalid <= 1'b0;
            end
            if (rd_fire) begin
                s_rvalid <= 1'b1;
            end else if (s_rready) begin
                s_rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rd_fire) begin
            s_rdata <= '0;
            case (s_araddr)
                REG_CTRL: begin
                    s_rdata[CTRL_ARM_BIT] <= (state == TRIG_ARMED);
                    s_rdata[CTRL_SEL_BIT +: CH_WIDTH] <= trig_sel;
                end
                REG_LEVEL: s_rdata[SAMPLE_WIDTH-1:0] <= level;
                REG_PRE:   s_rdata[INDEX_WIDTH-1:0]  <= pre_count;
                REG_BASE:  s_rdata[ADDR_WIDTH-1:0]   <= base_addr;
                REG_STATUS: begin
                    s_rdata[STATUS_ARMED_BIT] <= (state == TRIG_ARMED);
                    s_rdata[STATUS_TRIG_BIT]  <= (state == TRIG_TRIGGERED);
                    s_rdata[STATUS_DONE_BIT]  <= complete;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            state      <= TRIG_IDLE;
            trigger    <= 1'b0;
            complete   <= 1'b0;
            prev_valid <= 1'b0;
            stored     <= '0;
        end else begin
            trigger <= crossing;
            if (dma_done) begin
                state    <= TRIG_IDLE;
                complete <= 1'b1;
            end else if (arm_req) begin
                state      <= TRIG_ARMED;
                complete   <= 1'b0;
                prev_valid <= 1'b0;
                stored     <= '0;
            end else if (state == TRIG_ARMED && in_valid) begin
                prev_valid <= 1'b1;
                // Saturates, PRE can never exceed DEPTH-1
                if (stored != INDEX_WIDTH'(DEPTH - 1)) begin
                    stored <= stored + 1'b1;
                end
                if (crossing) begin
                    state <= TRIG_TRIGGERED;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (state == TRIG_ARMED && in_valid) begin
            prev_sample <= watched;
        end
    end

endmodule

// File: capture_buffer.sv
/* Circular sample memory of one channel.
   The trigger pulse arrives one cycle after the crossing sample was written.
   The memory keeps writing while FILLING, so old samples are overwritten. */
`timescale 1ns/1ps

module capture_buffer import scope_pkg::*; (
    input  logic                    clock,
    input  logic                    rst,
    input  logic                    in_valid,
    input  logic [SAMPLE_WIDTH-1:0] sample,
    input  logic                    trigger,
    input  logic [INDEX_WIDTH-1:0]  pre_count,
    input  logic                    capture_clear,
    capture_rd_if.buffer            rd
);

    buf_state_t              state;
    logic [SAMPLE_WIDTH-1:0] mem [DEPTH];
    logic [INDEX_WIDTH-1:0]  wr_ptr;
    logic [INDEX_WIDTH-1:0]  start_ptr;
    logic [INDEX_WIDTH-1:0]  rd_addr;
    logic [INDEX_WIDTH-1:0]  post_left;
    logic [INDEX_WIDTH-1:0]  post_target;
    logic                    wr_en;

    // Samples still needed after the trigger sample itself
    assign post_target = INDEX_WIDTH'(DEPTH - 1) - pre_count;

    always_comb begin
        case (state)
            // With no post samples needed, a sample on the trigger cycle
            // would overwrite the oldest pre-trigger entry
            BUF_FILLING: wr_en = in_valid && !(trigger && post_target == '0);
            BUF_POST:    wr_en = in_valid;
            default:     wr_en = 1'b0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            state     <= BUF_FILLING;
            wr_ptr    <= '0;
            start_ptr <= '0;
            post_left <= '0;
        end else if (capture_clear) begin
            state  <= BUF_FILLING;
            wr_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            case (state)
                BUF_FILLING: begin
                    if (trigger) begin
                        // The crossing sample sits just behind the write pointer
                        start_ptr <= wr_ptr - 1'b1 - pre_count;
                        if (post_target == INDEX_WIDTH'(wr_en)) begin
                            state <= BUF_FULL;
                        end else begin
                            post_left <= post_target - INDEX_WIDTH'(wr_en);
                            state     <= BUF_POST;
                        end
                    end
                end
                BUF_POST: begin
                    if (in_valid) begin
                        post_left <= post_left - 1'b1;
                        if (post_left == INDEX_WIDTH'(1)) begin
                            state <= BUF_FULL;
                        end
                    end
                end
                default: ;
            endcase
        end
    end

    // Index 0 of a read is the oldest retained pre-trigger sample
    assign rd_addr = start_ptr + rd.rd_index;
    assign rd.full = (state == BUF_FULL);

    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_ptr] <= sample;
        end
        if (rd.rd_en) begin
            rd.rd_data <= mem[rd_addr];
        end
    end

endmodule

// File: dma_engine.sv
/* Drains all capture buffers to the memory write port, channel by channel.
   One sample is in flight at a time, so a transfer takes two cycles per
   sample at best. base_addr must stay constant while a transfer runs. */
`timescale 1ns/1ps

module dma_engine import scope_pkg::*; (
    input  logic                    clock,
    input  logic                    rst,
    input  logic                    disable_dma,
    input  logic [ADDR_WIDTH-1:0]   base_addr,
    input  logic                    wr_ready,
    capture_rd_if.engine            rd [N_CHANNELS],
    output logic                    wr_valid,
    output logic [ADDR_WIDTH-1:0]   wr_addr,
    output logic [SAMPLE_WIDTH-1:0] wr_data,
    output logic                    dma_done
);

    dma_state_t                                    state;
    logic [CH_WIDTH-1:0]                           ch;
    logic [INDEX_WIDTH-1:0]                        idx;
    logic [N_CHANNELS-1:0]                         full_vec;
    logic [N_CHANNELS-1:0][SAMPLE_WIDTH-1:0]       data_vec;
    logic                                          last;

    for (genvar g = 0; g < N_CHANNELS; g++) begin : g_rd
        assign full_vec[g]    = rd[g].full;
        assign data_vec[g]    = rd[g].rd_data;
        assign rd[g].rd_en    = (state == DMA_REQUEST) && (ch == CH_WIDTH'(g));
        assign rd[g].rd_index = idx;
    end

    // DEPTH is a power of two, so c*DEPTH + k is the concatenation {c, k}
    assign wr_addr  = base_addr + ADDR_WIDTH'({ch, idx});
    assign wr_data  = data_vec[ch];
    assign wr_valid = (state == DMA_WRITE);
    assign dma_done = (state == DMA_DONE);
    assign last     = (idx == INDEX_WIDTH'(DEPTH - 1)) && (ch == CH_WIDTH'(N_CHANNELS - 1));

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= DMA_IDLE;
            ch    <= '0;
            idx   <= '0;
        end else begin
            case (state)
                DMA_IDLE: begin
                    if (&full_vec && !disable_dma) begin
                        ch    <= '0;
                        idx   <= '0;
                        state <= DMA_REQUEST;
                    end
                end
                // Read data shows up one cycle later and holds while stalled
                DMA_REQUEST: state <= DMA_WRITE;
                DMA_WRITE: begin
                    if (wr_ready) begin
                        if (last) begin
                            state <= DMA_DONE;
                        end else begin
                            {ch, idx} <= {ch, idx} + 1'b1;
                            state     <= DMA_REQUEST;
                        end
                    end
                end
                default: state <= DMA_IDLE;
            endcase
        end
    end

endmodule

// File: scope_dma.sv
/* Top level of the multi-channel capture block.
   All channels share in_valid and there is no input back-pressure. Samples
   that arrive while the buffers are full or being drained are lost. */
`timescale 1ns/1ps

module scope_dma import scope_pkg::*; (
    input  logic                                   clock,
    input  logic                                   rst,
    input  logic                                   in_valid,
    input  logic [N_CHANNELS-1:0][SAMPLE_WIDTH-1:0] in_data,
    input  logic                                   disable_dma,
    input  logic [AXI_ADDR_WIDTH-1:0]              s_awaddr,
    input  logic                                   s_awvalid,
    output logic                                   s_awready,
    input  logic [AXI_DATA_WIDTH-1:0]              s_wdata,
    input  logic                                   s_wvalid,
    output logic                                   s_wready,
    output logic [1:0]                             s_bresp,
    output logic                                   s_bvalid,
    input  logic                                   s_bready,
    input  logic [AXI_ADDR_WIDTH-1:0]              s_araddr,
    input  logic                                   s_arvalid,
    output logic                                   s_arready,
    output logic [AXI_DATA_WIDTH-1:0]              s_rdata,
    output logic [1:0]                             s_rresp,
    output logic                                   s_rvalid,
    input  logic                                   s_rready,
    output logic                                   wr_valid,
    input  logic                                   wr_ready,
    output logic [ADDR_WIDTH-1:0]                  wr_addr,
    output logic [SAMPLE_WIDTH-1:0]                wr_data,
    output logic                                   dma_done
);

    logic                   trigger;
    logic [INDEX_WIDTH-1:0] pre_count;
    logic [ADDR_WIDTH-1:0]  base_addr;
    logic                   capture_clear;

    capture_rd_if rd_bus [N_CHANNELS] ();

    trigger_engine u_trigger (
        .clock         (clock),
        .rst           (rst),
        .in_valid      (in_valid),
        .in_data       (in_data),
        .dma_done      (dma_done),
        .s_awaddr      (s_awaddr),
        .s_awvalid     (s_awvalid),
        .s_awready     (s_awready),
        .s_wdata       (s_wdata),
        .s_wvalid      (s_wvalid),
        .s_wready      (s_wready),
        .s_bresp       (s_bresp),
        .s_bvalid      (s_bvalid),
        .s_bready      (s_bready),
        .s_araddr      (s_araddr),
        .s_arvalid     (s_arvalid),
        .s_arready     (s_arready),
        .s_rdata       (s_rdata),
        .s_rresp       (s_rresp),
        .s_rvalid      (s_rvalid),
        .s_rready      (s_rready),
        .trigger       (trigger),
        .pre_count     (pre_count),
        .base_addr     (base_addr),
        .capture_clear (capture_clear)
    );

    for (genvar g = 0; g < N_CHANNELS; g++) begin : g_buf
        capture_buffer u_buffer (
            .clock         (clock),
            .rst           (rst),
            .in_valid      (in_valid),
            .sample        (in_data[g]),
            .trigger       (trigger),
            .pre_count     (pre_count),
            .capture_clear (capture_clear),
            .rd            (rd_bus[g])
        );
    end

    dma_engine u_dma (
        .clock       (clock),
        .rst         (rst),
        .disable_dma (disable_dma),
        .base_addr   (base_addr),
        .wr_ready    (wr_ready),
        .rd          (rd_bus),
        .wr_valid    (wr_valid),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .dma_done    (dma_done)
    );

endmodule

// File: scope_checker.sv
/* Handshake assertions on scope_dma, bound into every instance of it.
   The failure count is read by the testbench at the end of the run. */
`timescale 1ns/1ps

module scope_checker import scope_pkg::*; (
    input logic                    clock,
    input logic                    rst,
    input logic                    wr_valid,
    input logic                    wr_ready,
    input logic [ADDR_WIDTH-1:0]   wr_addr,
    input logic [SAMPLE_WIDTH-1:0] wr_data,
    input logic                    s_bvalid,
    input logic                    s_bready,
    input logic                    dma_done
);

    int failures = 0;

    // A stalled write keeps its address and data until wr_ready
    write_held: assert property (@(posedge clock) disable iff (rst)
        wr_valid && !wr_ready |=> wr_valid && $stable(wr_addr) && $stable(wr_data))
    else begin
        $error("write port changed while wr_ready was low");
        failures++;
    end

    bvalid_held: assert property (@(posedge clock) disable iff (rst)
        s_bvalid && !s_bready |=> s_bvalid)
    else begin
        $error("bvalid dropped before bready");
        failures++;
    end

    done_pulse: assert property (@(posedge clock) disable iff (rst)
        dma_done |=> !dma_done)
    else begin
        $error("dma_done lasted more than one cycle");
        failures++;
    end

endmodule

bind scope_dma scope_checker u_checker (
    .clock    (clock),
    .rst      (rst),
    .wr_valid (wr_valid),
    .wr_ready (wr_ready),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .s_bvalid (s_bvalid),
    .s_bready (s_bready),
    .dma_done (dma_done)
);

// File: scope_monitor.sv
/* Watches the memory write port and compares each handshake with the next
   expected address and data, queued by the testbench before the DMA starts. */
`timescale 1ns/1ps

module scope_monitor import scope_pkg::*; (
    input logic                    clock,
    input logic                    rst,
    input logic                    wr_valid,
    input logic                    wr_ready,
    input logic [ADDR_WIDTH-1:0]   wr_addr,
    input logic [SAMPLE_WIDTH-1:0] wr_data,
    input logic                    disable_dma
);

    logic [ADDR_WIDTH-1:0]   exp_addr [$];
    logic [SAMPLE_WIDTH-1:0] exp_data [$];
    int                      error_count  = 0;
    int                      test_errors  = 0;
    int                      write_count  = 0;
    int                      tests_failed = 0;

    task automatic note_failure(input string what);
        $display("%s", what);
        error_count++;
        test_errors++;
    endtask

    task automatic expect_write(input logic [ADDR_WIDTH-1:0] addr,
                                input logic [SAMPLE_WIDTH-1:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic check_register(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        if (got !== exp) begin
            note_failure($sformatf("error at %0t: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic finish_test(input int id);
        if (exp_addr.size() != 0) begin
            note_failure($sformatf("test %0d: %0d expected writes never appeared",
                                   id, exp_addr.size()));
            exp_addr.delete();
            exp_data.delete();
        end
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("test %0d %s: %0d writes, %0d errors", id,
                 (test_errors == 0) ? "ok" : "FAILED", write_count, test_errors);
        test_errors = 0;
        write_count = 0;
    endtask

    always @(posedge clock) begin : watch_writes
        logic [ADDR_WIDTH-1:0]   a;
        logic [SAMPLE_WIDTH-1:0] d;
        if (!rst && wr_valid && wr_ready) begin
            write_count++;
            if (disable_dma) begin
                note_failure($sformatf("write to %h at %0t while disable_dma was high",
                                       wr_addr, $time));
            end
            if (exp_addr.size() == 0) begin
                note_failure($sformatf("extra write to %h at %0t, none was expected",
                                       wr_addr, $time));
            end else begin
                a = exp_addr.pop_front();
                d = exp_data.pop_front();
                if (wr_addr !== a) begin
                    note_failure($sformatf("error at %0t: wr_addr is %h, expected %h",
                                           $time, wr_addr, a));
                end
                if (wr_data !== d) begin
                    note_failure($sformatf("error at %0t: wr_data is %h, expected %h",
                                           $time, wr_data, d));
                end
            end
        end
    end

endmodule

// File: scope_tb.sv
/* Testbench for scope_dma. Each table entry programs the registers, arms the
   trigger, drives one capture and waits for dma_done. A private copy of the
   samples gives the expected trigger point and write sequence. */
`timescale 1ns/1ps

module scope_tb import scope_pkg::*;;

    localparam int CLK_PERIOD  = 100;
    localparam int N_TESTS     = 5;
    localparam int MAX_SAMPLES = 64;
    localparam int HOLD_CYCLES = 20;

    typedef struct packed {
        logic [SAMPLE_WIDTH-1:0] level;
        logic [INDEX_WIDTH-1:0]  pre;
        logic [CH_WIDTH-1:0]     sel;
        logic [ADDR_WIDTH-1:0]   base;
        logic                    ramp;
        logic                    stall;
        logic                    hold_dma;
    } test_entry_t;

    logic                                    clock;
    logic                                    rst;
    logic                                    in_valid;
    logic [N_CHANNELS-1:0][SAMPLE_WIDTH-1:0] in_data;
    logic                                    disable_dma;
    logic [AXI_ADDR_WIDTH-1:0]               s_awaddr;
    logic                                    s_awvalid;
    logic                                    s_awready;
    logic [AXI_DATA_WIDTH-1:0]               s_wdata;
    logic                                    s_wvalid;
    logic                                    s_wready;
    logic [1:0]                              s_bresp;
    logic                                    s_bvalid;
    logic                                    s_bready;
    logic [AXI_ADDR_WIDTH-1:0]               s_araddr;
    logic                                    s_arvalid;
    logic                                    s_arready;
    logic [AXI_DATA_WIDTH-1:0]               s_rdata;
    logic [1:0]                              s_rresp;
    logic                                    s_rvalid;
    logic                                    s_rready;
    logic                                    wr_valid;
    logic                                    wr_ready;
    logic [ADDR_WIDTH-1:0]                   wr_addr;
    logic [SAMPLE_WIDTH-1:0]                 wr_data;
    logic                                    dma_done;

    logic                                    stall_enable;
    test_entry_t                             tests [N_TESTS];
    logic [N_CHANNELS-1:0][SAMPLE_WIDTH-1:0] history [MAX_SAMPLES];
    int                                      tests_done;

    scope_dma DUT (.*);

    scope_monitor u_monitor (
        .clock       (clock),
        .rst         (rst),
        .wr_valid    (wr_valid),
        .wr_ready    (wr_ready),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .disable_dma (disable_dma)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    initial begin
        #(N_TESTS * MAX_SAMPLES * 20 * CLK_PERIOD);
        $display("Watchdog expired after %0t with %0d tests done", $time, tests_done);
        $display("Some tests failed");
        $finish;
    end

    // Random stalls on the write port for the entries that ask for them
    task automatic stall_write_port();
        forever begin
            @(negedge clock);
            wr_ready = stall_enable ? 1'($urandom % 2) : 1'b1;
        end
    endtask

    task automatic axi_write(input logic [AXI_ADDR_WIDTH-1:0] addr,
                             input logic [AXI_DATA_WIDTH-1:0] data);
        @(negedge clock);
        s_awaddr  = addr;
        s_wdata   = data;
        s_awvalid = 1'b1;
        s_wvalid  = 1'b1;
        // Address and data are taken on the edge where both readies are high
        do @(posedge clock); while (!(s_awready && s_wready));
        @(negedge clock);
        s_awvalid = 1'b0;
        s_wvalid  = 1'b0;
        if (!s_bvalid) begin
            u_monitor.note_failure($sformatf("no write response one cycle after the handshake at %0t",
                                             $time));
        end
        u_monitor.check_register("s_bresp", 32'(s_bresp), 32'(AXI_RESP_OKAY));
        // bready comes a cycle late, so bvalid has to wait for it
        @(negedge clock);
        s_bready  = 1'b1;
        @(negedge clock);
        s_bready  = 1'b0;
    endtask

    task automatic axi_read(input logic [AXI_ADDR_WIDTH-1:0] addr,
                            output logic [AXI_DATA_WIDTH-1:0] data);
        @(negedge clock);
        s_araddr  = addr;
        s_arvalid = 1'b1;
        do @(posedge clock); while (!s_arready);
        @(negedge clock);
        s_arvalid = 1'b0;
        if (!s_rvalid) begin
            u_monitor.note_failure($sformatf("no read data one cycle after the handshake at %0t",
                                             $time));
        end
        data      = s_rdata;
        u_monitor.check_register("s_rresp", 32'(s_rresp), 32'(AXI_RESP_OKAY));
        s_rready  = 1'b1;
        @(negedge clock);
        s_rready  = 1'b0;
    endtask

    function automatic logic [N_CHANNELS-1:0][SAMPLE_WIDTH-1:0] make_sample(
        input logic ramp, input int n);
        logic [N_CHANNELS-1:0][SAMPLE_WIDTH-1:0] s;
        for (int c = 0; c < N_CHANNELS; c++) begin
            s[c] = ramp ? SAMPLE_WIDTH'(n * 256 + c * 16'h4000) : SAMPLE_WIDTH'($urandom);
        end
        return s;
    endfunction

    // Channel c, index k lands at BASE + c*DEPTH + k
    // Index 0 of every channel is the sample numbered first
    task automatic queue_capture(input test_entry_t t, input int first);
        for (int c = 0; c < N_CHANNELS; c++) begin
            for (int k = 0; k < DEPTH; k++) begin
                u_monitor.expect_write(ADDR_WIDTH'(t.base + c * DEPTH + k),
                                       history[first + k][c]);
            end
        end
    endtask

    task automatic run_test(input int id, input test_entry_t t, output logic ok);
        logic [AXI_DATA_WIDTH-1:0]               status;
        logic [N_CHANNELS-1:0][SAMPLE_WIDTH-1:0] s;
        int                                      n;
        int                                      trig;
        int                                      need;
        n    = 0;
        trig = -1;
        need = MAX_SAMPLES;
        ok   = 1'b1;
        @(negedge clock);
        disable_dma  = t.hold_dma;
        stall_enable = t.stall;
        axi_write(REG_LEVEL, AXI_DATA_WIDTH'(t.level));
        axi_write(REG_PRE, AXI_DATA_WIDTH'(t.pre));
        axi_write(REG_BASE, AXI_DATA_WIDTH'(t.base));
        axi_write(REG_CTRL, (AXI_DATA_WIDTH'(t.sel) << CTRL_SEL_BIT) | (32'd1 << CTRL_ARM_BIT));
        axi_read(REG_STATUS, status);
        u_monitor.check_register("STATUS after arm", status, 32'd1 << STATUS_ARMED_BIT);

        // Two extra samples after the capture must be dropped by the buffers
        while (n < MAX_SAMPLES && (trig < 0 || n < need + 2)) begin
            @(negedge clock);
            if (!t.ramp && ($urandom % 4) == 0) begin
                in_valid = 1'b0;
                in_data  = make_sample(1'b0, n);
            end else begin
                s          = make_sample(t.ramp, n);
                in_valid   = 1'b1;
                in_data    = s;
                history[n] = s;
                if (trig < 0 && n >= 1 && n >= int'(t.pre)
                    && history[n - 1][t.sel] < t.level && s[t.sel] >= t.level) begin
                    trig = n;
                    need = n - int'(t.pre) + DEPTH;
                end
                n++;
                if (trig >= 0 && n == need) begin
                    queue_capture(t, trig - int'(t.pre));
                end
            end
        end
        @(negedge clock);
        in_valid = 1'b0;
        if (trig < 0 || n < need) begin
            u_monitor.note_failure($sformatf("test %0d found no complete capture in %0d samples",
                                             id, MAX_SAMPLES));
            ok = 1'b0;
        end else begin
            if (t.hold_dma) begin
                repeat (HOLD_CYCLES) @(negedge clock);
                disable_dma = 1'b0;
            end
            do @(negedge clock); while (!dma_done);
            axi_read(REG_STATUS, status);
            u_monitor.check_register("STATUS after done", status, 32'd1 << STATUS_DONE_BIT);
        end
        u_monitor.finish_test(id);
    endtask

    initial begin
        logic ok;
        void'($urandom(25));
        rst          = 1'b1;
        in_valid     = 1'b0;
        in_data      = '0;
        disable_dma  = 1'b0;
        s_awaddr     = '0;
        s_awvalid    = 1'b0;
        s_wdata      = '0;
        s_wvalid     = 1'b0;
        s_bready     = 1'b0;
        s_araddr     = '0;
        s_arvalid    = 1'b0;
        s_rready     = 1'b0;
        wr_ready     = 1'b1;
        stall_enable = 1'b0;
        tests_done   = 0;
        fork
            stall_write_port();
        join_none
        // Level, PRE, channel, BASE, ramp, stall, hold DMA
        tests[0] = '{16'h0400, 4'd4, 1'd0, 16'h1000, 1'b1, 1'b0, 1'b0};
        tests[1] = '{16'h8000, 4'd6, 1'd1, 16'h2000, 1'b0, 1'b0, 1'b0};
        tests[2] = '{16'h6000, 4'd3, 1'd0, 16'h3000, 1'b0, 1'b1, 1'b0};
        tests[3] = '{16'h0400, 4'd4, 1'd0, 16'h0040, 1'b1, 1'b0, 1'b1};
        tests[4] = '{16'h9000, 4'd10, 1'd1, 16'hFFF0, 1'b0, 1'b1, 1'b0};
        repeat (10) @(negedge clock);
        rst = 1'b0;
        for (int i = 0; i < N_TESTS; i++) begin
            run_test(i, tests[i], ok);
            if (!ok) begin
                break;
            end
            tests_done++;
        end
        repeat (5) @(negedge clock);
        $display("%0d of %0d tests run, %0d failed, %0d errors, %0d assertion failures",
                 tests_done, N_TESTS, u_monitor.tests_failed, u_monitor.error_count,
                 DUT.u_checker.failures);
        if (tests_done == N_TESTS && u_monitor.error_count == 0
            && DUT.u_checker.failures == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: sources.f
scope_pkg.sv
scope_if.sv
trigger_engine.sv
capture_buffer.sv
dma_engine.sv
scope_dma.sv
scope_checker.sv
scope_monitor.sv
scope_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks for the pass message.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module scope_tb -o scope_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/scope_sim +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "All tests passed"; then
    exit 0
fi
exit 1
